// File: hdl/fabric_pkg.sv
package fabric_pkg;

	// ------------------------------------------------------------
	// basic words
	// ------------------------------------------------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;

	// requester side
	typedef struct packed {
		logic  valid;
		addr_t addr;
	} fetch_req_t;

	typedef struct packed {
		logic  valid;
		logic  write;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
	} bus_req_t;

	typedef struct packed {
		logic  valid;
		logic  err;
		data_t rdata;
	} bus_rsp_t;

	// ------------------------------------------------------------
	// axi4 channel payloads, valid/ready travel beside them
	// ------------------------------------------------------------
	typedef struct packed {
		addr_t      addr;
		logic [3:0] id;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_aw_t;

	typedef struct packed {
		addr_t      addr;
		logic [3:0] id;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_ar_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic  last;
	} axi_w_t;

	typedef struct packed {
		data_t      data;
		logic [1:0] resp;
		logic [3:0] id;
		logic       last;
	} axi_r_t;

	typedef struct packed {
		logic [1:0] resp;
		logic [3:0] id;
	} axi_b_t;

	// ------------------------------------------------------------
	// state and selector encodings
	// ------------------------------------------------------------
	typedef enum logic [1:0] {GNT_NONE, GNT_FETCH, GNT_DATA} grant_e;
	typedef enum logic [1:0] {TGT_NONE, TGT_CLINT, TGT_EXT} target_e;
	typedef enum logic [2:0] {BR_IDLE, BR_AR, BR_R, BR_AW_W, BR_B} bridge_state_e;

	// axi field values for a single word beat
	localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;
	localparam logic [1:0] AXI_BURST_INCR = 2'd1;
	localparam logic [1:0] AXI_RESP_OKAY  = 2'd0;

	// mtime word offsets inside the clint window
	localparam addr_t MTIME_LO_OFS = 32'h0000_BFF8;
	localparam addr_t MTIME_HI_OFS = 32'h0000_BFFC;

endpackage

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
	import fabric_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n_i,
	input  fetch_req_t fetch_req_i,
	output bus_rsp_t   fetch_rsp_o,
	input  bus_req_t   data_req_i,
	output bus_rsp_t   data_rsp_o,
	output bus_req_t   gnt_req_o,
	input  bus_rsp_t   gnt_rsp_i
);

	grant_e owner_q;

	// ------------------------------------------------------------
	// owner register
	// ------------------------------------------------------------
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			owner_q <= GNT_NONE;
		end else begin
			case (owner_q)
				GNT_NONE: begin
					// data port wins a tie
					if (data_req_i.valid) begin
						owner_q <= GNT_DATA;
					end else if (fetch_req_i.valid) begin
						owner_q <= GNT_FETCH;
					end
				end
				default: begin
					if (gnt_rsp_i.valid) begin
						owner_q <= GNT_NONE;
					end
				end
			endcase
		end
	end

	// granted request, fetch turns into a full word read
	always_comb begin
		case (owner_q)
			GNT_FETCH: begin
				gnt_req_o = '{
					valid: fetch_req_i.valid,
					write: 1'b0,
					addr:  fetch_req_i.addr,
					wdata: '0,
					wstrb: 4'hF
				};
			end
			GNT_DATA: begin
				gnt_req_o = data_req_i;
			end
			default: begin
				gnt_req_o = '0;
			end
		endcase
	end

	// response steering, only the owner sees valid
	always_comb begin
		fetch_rsp_o = gnt_rsp_i;
		data_rsp_o  = gnt_rsp_i;
		fetch_rsp_o.valid = gnt_rsp_i.valid && (owner_q == GNT_FETCH);
		data_rsp_o.valid  = gnt_rsp_i.valid && (owner_q == GNT_DATA);
	end

	a_one_rsp: assert property (@(posedge clock) disable iff (!rst_n_i)
		!(fetch_rsp_o.valid && data_rsp_o.valid));

	// downstream must never answer a request that was not granted
	a_rsp_has_owner: assert property (@(posedge clock) disable iff (!rst_n_i)
		gnt_rsp_i.valid |-> owner_q != GNT_NONE);

endmodule

// File: hdl/addr_xbar.sv
`timescale 1ns/1ps

module addr_xbar
	import fabric_pkg::*;
#(
	parameter addr_t       CLINT_BASE      = 32'h0200_0000,
	parameter int unsigned CLINT_SPAN_BITS = 16
) (
	input  logic     clock,
	input  logic     rst_n_i,
	input  bus_req_t gnt_req_i,
	output bus_rsp_t gnt_rsp_o,
	output bus_req_t clint_req_o,
	input  bus_rsp_t clint_rsp_i,
	output bus_req_t ext_req_o,
	input  bus_rsp_t ext_rsp_i
);

	target_e tgt_q;
	target_e tgt_now;
	logic    hit_clint;

	// upper bits select the timer window
	assign hit_clint = (gnt_req_i.addr[31:CLINT_SPAN_BITS] == CLINT_BASE[31:CLINT_SPAN_BITS]);

	// route in the grant cycle, then hold the latched target
	always_comb begin
		tgt_now = tgt_q;
		if ((tgt_q == TGT_NONE) && gnt_req_i.valid) begin
			tgt_now = hit_clint ? TGT_CLINT : TGT_EXT;
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tgt_q <= TGT_NONE;
		end else if (gnt_rsp_o.valid) begin
			tgt_q <= TGT_NONE;
		end else if ((tgt_q == TGT_NONE) && gnt_req_i.valid) begin
			tgt_q <= tgt_now;
		end
	end

	// ------------------------------------------------------------
	// request fan-out and response select
	// ------------------------------------------------------------
	always_comb begin
		clint_req_o = gnt_req_i;
		ext_req_o   = gnt_req_i;
		clint_req_o.valid = gnt_req_i.valid && (tgt_now == TGT_CLINT);
		ext_req_o.valid   = gnt_req_i.valid && (tgt_now == TGT_EXT);
	end

	always_comb begin
		case (tgt_now)
			TGT_CLINT: gnt_rsp_o = clint_rsp_i;
			TGT_EXT:   gnt_rsp_o = ext_rsp_i;
			default:   gnt_rsp_o = '0;
		endcase
	end

	a_clint_rsp_routed: assert property (@(posedge clock) disable iff (!rst_n_i)
		clint_rsp_i.valid |-> tgt_q == TGT_CLINT);

	a_ext_rsp_routed: assert property (@(posedge clock) disable iff (!rst_n_i)
		ext_rsp_i.valid |-> tgt_q == TGT_EXT);

endmodule

// File: hdl/clint_timer.sv
`timescale 1ns/1ps

module clint_timer
	import fabric_pkg::*;
#(
	parameter int unsigned CLINT_SPAN_BITS = 16
) (
	input  logic     clock,
	input  logic     rst_n_i,
	input  bus_req_t clint_req_i,
	output bus_rsp_t clint_rsp_o
);

	logic [63:0] mtime_q;
	logic        rsp_valid_q;
	data_t       rsp_rdata_q;
	logic        take;
	logic        hit_lo;
	logic        hit_hi;

	// byte lanes from wdata where strobed, old word elsewhere
	function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
		data_t res;
		res = old_w;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return res;
	endfunction

	// one access per request, the response cycle does not count
	assign take   = clint_req_i.valid && !rsp_valid_q;
	assign hit_lo = (clint_req_i.addr[CLINT_SPAN_BITS-1:2] == MTIME_LO_OFS[CLINT_SPAN_BITS-1:2]);
	assign hit_hi = (clint_req_i.addr[CLINT_SPAN_BITS-1:2] == MTIME_HI_OFS[CLINT_SPAN_BITS-1:2]);

	// ------------------------------------------------------------
	// mtime counter
	// ------------------------------------------------------------
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mtime_q <= '0;
		end else if (take && clint_req_i.write && hit_lo) begin
			mtime_q[31:0] <= merge_bytes(mtime_q[31:0], clint_req_i.wdata, clint_req_i.wstrb);
		end else if (take && clint_req_i.write && hit_hi) begin
			mtime_q[63:32] <= merge_bytes(mtime_q[63:32], clint_req_i.wdata, clint_req_i.wstrb);
		end else begin
			mtime_q <= mtime_q + 64'd1;
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= take;
		end
	end

	// read data, writes and stray offsets give zero
	always_ff @(posedge clock) begin
		if (take) begin
			if (clint_req_i.write) begin
				rsp_rdata_q <= '0;
			end else if (hit_lo) begin
				rsp_rdata_q <= mtime_q[31:0];
			end else if (hit_hi) begin
				rsp_rdata_q <= mtime_q[63:32];
			end else begin
				rsp_rdata_q <= '0;
			end
		end
	end

	assign clint_rsp_o = '{valid: rsp_valid_q, err: 1'b0, rdata: rsp_rdata_q};

endmodule

// File: hdl/axi4_master_bridge.sv
`timescale 1ns/1ps

module axi4_master_bridge
	import fabric_pkg::*;
(
	input  logic     clock,
	input  logic     rst_n_i,
	input  bus_req_t ext_req_i,
	output bus_rsp_t ext_rsp_o,
	output axi_aw_t  axi_aw_o,
	output logic     axi_awvalid_o,
	input  logic     axi_awready_i,
	output axi_w_t   axi_w_o,
	output logic     axi_wvalid_o,
	input  logic     axi_wready_i,
	input  axi_b_t   axi_b_i,
	input  logic     axi_bvalid_i,
	output logic     axi_bready_o,
	output axi_ar_t  axi_ar_o,
	output logic     axi_arvalid_o,
	input  logic     axi_arready_i,
	input  axi_r_t   axi_r_i,
	input  logic     axi_rvalid_i,
	output logic     axi_rready_o
);

	bridge_state_e state_q;
	logic          arvalid_q;
	logic          awvalid_q;
	logic          wvalid_q;
	logic          rsp_valid_q;
	logic          rsp_err_q;
	data_t         rsp_rdata_q;
	logic          aw_done;
	logic          w_done;

	// aw and w retire independently
	assign aw_done = !awvalid_q || axi_awready_i;
	assign w_done  = !wvalid_q || axi_wready_i;

	// ------------------------------------------------------------
	// single beat fsm
	// ------------------------------------------------------------
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= BR_IDLE;
			arvalid_q   <= 1'b0;
			awvalid_q   <= 1'b0;
			wvalid_q    <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= 1'b0;
			case (state_q)
				BR_IDLE: begin
					// request is still up during its own response cycle
					if (ext_req_i.valid && !rsp_valid_q) begin
						if (ext_req_i.write) begin
							state_q   <= BR_AW_W;
							awvalid_q <= 1'b1;
							wvalid_q  <= 1'b1;
						end else begin
							state_q   <= BR_AR;
							arvalid_q <= 1'b1;
						end
					end
				end
				BR_AR: begin
					if (axi_arready_i) begin
						arvalid_q <= 1'b0;
						state_q   <= BR_R;
					end
				end
				BR_R: begin
					if (axi_rvalid_i) begin
						rsp_valid_q <= 1'b1;
						state_q     <= BR_IDLE;
					end
				end
				BR_AW_W: begin
					if (axi_awready_i) begin
						awvalid_q <= 1'b0;
					end
					if (axi_wready_i) begin
						wvalid_q <= 1'b0;
					end
					if (aw_done && w_done) begin
						state_q <= BR_B;
					end
				end
				BR_B: begin
					if (axi_bvalid_i) begin
						rsp_valid_q <= 1'b1;
						state_q     <= BR_IDLE;
					end
				end
				default: state_q <= BR_IDLE;
			endcase
		end
	end

	// response payload, writes return zero
	always_ff @(posedge clock) begin
		if ((state_q == BR_R) && axi_rvalid_i) begin
			rsp_rdata_q <= axi_r_i.data;
			rsp_err_q   <= (axi_r_i.resp != AXI_RESP_OKAY);
		end else if ((state_q == BR_B) && axi_bvalid_i) begin
			rsp_rdata_q <= '0;
			rsp_err_q   <= (axi_b_i.resp != AXI_RESP_OKAY);
		end
	end

	assign ext_rsp_o = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rsp_rdata_q};

	// payloads come straight from the held request
	assign axi_ar_o = '{addr: ext_req_i.addr, id: 4'd0, len: 8'd0,
		size: AXI_SIZE_WORD, burst: AXI_BURST_INCR};
	assign axi_aw_o = '{addr: ext_req_i.addr, id: 4'd0, len: 8'd0,
		size: AXI_SIZE_WORD, burst: AXI_BURST_INCR};
	assign axi_w_o  = '{data: ext_req_i.wdata, strb: ext_req_i.wstrb, last: 1'b1};

	assign axi_arvalid_o = arvalid_q;
	assign axi_awvalid_o = awvalid_q;
	assign axi_wvalid_o  = wvalid_q;
	assign axi_rready_o  = (state_q == BR_R);
	assign axi_bready_o  = (state_q == BR_B);

	a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o);

	a_aw_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o);

	a_req_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
		(state_q != BR_IDLE) |-> $stable(ext_req_i));

	// slave has to answer the single beat with id 0 and last
	a_r_single: assert property (@(posedge clock) disable iff (!rst_n_i)
		axi_rvalid_i && axi_rready_o |-> axi_r_i.last && (axi_r_i.id == 4'd0));

	a_b_id: assert property (@(posedge clock) disable iff (!rst_n_i)
		axi_bvalid_i && axi_bready_o |-> axi_b_i.id == 4'd0);

endmodule

// File: hdl/core_bus_top.sv
`timescale 1ns/1ps

module core_bus_top
	import fabric_pkg::*;
#(
	parameter addr_t       CLINT_BASE      = 32'h0200_0000,
	parameter int unsigned CLINT_SPAN_BITS = 16
) (
	input  logic       clock,
	input  logic       rst_n_i,

	// requesters
	input  fetch_req_t fetch_req_i,
	output bus_rsp_t   fetch_rsp_o,
	input  bus_req_t   data_req_i,
	output bus_rsp_t   data_rsp_o,

	// ------------------------------------------------------------
	// axi4 master at the chip boundary
	// ------------------------------------------------------------
	output axi_aw_t    axi_aw_o,
	output logic       axi_awvalid_o,
	input  logic       axi_awready_i,
	output axi_w_t     axi_w_o,
	output logic       axi_wvalid_o,
	input  logic       axi_wready_i,
	input  axi_b_t     axi_b_i,
	input  logic       axi_bvalid_i,
	output logic       axi_bready_o,
	output axi_ar_t    axi_ar_o,
	output logic       axi_arvalid_o,
	input  logic       axi_arready_i,
	input  axi_r_t     axi_r_i,
	input  logic       axi_rvalid_i,
	output logic       axi_rready_o
);

	bus_req_t gnt_req;
	bus_rsp_t gnt_rsp;
	bus_req_t clint_req;
	bus_rsp_t clint_rsp;
	bus_req_t ext_req;
	bus_rsp_t ext_rsp;

	bus_arbiter u_arbiter (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.fetch_req_i (fetch_req_i),
		.fetch_rsp_o (fetch_rsp_o),
		.data_req_i  (data_req_i),
		.data_rsp_o  (data_rsp_o),
		.gnt_req_o   (gnt_req),
		.gnt_rsp_i   (gnt_rsp)
	);

	addr_xbar #(
		.CLINT_BASE      (CLINT_BASE),
		.CLINT_SPAN_BITS (CLINT_SPAN_BITS)
	) u_xbar (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.gnt_req_i   (gnt_req),
		.gnt_rsp_o   (gnt_rsp),
		.clint_req_o (clint_req),
		.clint_rsp_i (clint_rsp),
		.ext_req_o   (ext_req),
		.ext_rsp_i   (ext_rsp)
	);

	clint_timer #(
		.CLINT_SPAN_BITS (CLINT_SPAN_BITS)
	) u_clint (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.clint_req_i (clint_req),
		.clint_rsp_o (clint_rsp)
	);

	axi4_master_bridge u_bridge (
		.clock         (clock),
		.rst_n_i       (rst_n_i),
		.ext_req_i     (ext_req),
		.ext_rsp_o     (ext_rsp),
		.axi_aw_o      (axi_aw_o),
		.axi_awvalid_o (axi_awvalid_o),
		.axi_awready_i (axi_awready_i),
		.axi_w_o       (axi_w_o),
		.axi_wvalid_o  (axi_wvalid_o),
		.axi_wready_i  (axi_wready_i),
		.axi_b_i       (axi_b_i),
		.axi_bvalid_i  (axi_bvalid_i),
		.axi_bready_o  (axi_bready_o),
		.axi_ar_o      (axi_ar_o),
		.axi_arvalid_o (axi_arvalid_o),
		.axi_arready_i (axi_arready_i),
		.axi_r_i       (axi_r_i),
		.axi_rvalid_i  (axi_rvalid_i),
		.axi_rready_o  (axi_rready_o)
	);

endmodule

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model
	import fabric_pkg::*;
#(
	parameter int unsigned WORDS    = 256,
	parameter addr_t       ERR_BASE = 32'hF000_0000,
	parameter logic [31:0] SEED     = 32'd94853
) (
	input  logic    clock,
	input  logic    rst_n_i,
	input  axi_aw_t axi_aw_i,
	input  logic    axi_awvalid_i,
	output logic    axi_awready_o,
	input  axi_w_t  axi_w_i,
	input  logic    axi_wvalid_i,
	output logic    axi_wready_o,
	output axi_b_t  axi_b_o,
	output logic    axi_bvalid_o,
	input  logic    axi_bready_i,
	input  axi_ar_t axi_ar_i,
	input  logic    axi_arvalid_i,
	output logic    axi_arready_o,
	output axi_r_t  axi_r_o,
	output logic    axi_rvalid_o,
	input  logic    axi_rready_i
);

	localparam int         IDX_BITS    = $clog2(WORDS);
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	data_t       mem [WORDS];
	logic [31:0] lfsr;
	logic [1:0]  aw_wait;
	logic [1:0]  w_wait;
	logic [1:0]  ar_wait;
	logic        aw_got;
	logic        w_got;
	addr_t       wr_addr;
	data_t       wr_data;
	strb_t       wr_strb;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// 0 to 3 cycles, one lfsr step per bit
	task automatic draw_delay(output logic [1:0] d);
		lfsr = lfsr_next(lfsr);
		d[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		d[1] = lfsr[0];
	endtask

	// word content follows its byte address
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = 32'hC0DE_0000 | (32'(i) << 2);
		end
	end

	assign axi_awready_o = axi_awvalid_i && (aw_wait == 2'd0) && !aw_got;
	assign axi_wready_o  = axi_wvalid_i && (w_wait == 2'd0) && !w_got;
	assign axi_arready_o = axi_arvalid_i && (ar_wait == 2'd0) && !axi_rvalid_o;

	always @(posedge clock or negedge rst_n_i) begin
		logic [1:0] d;
		if (!rst_n_i) begin
			lfsr = SEED;
			aw_wait      <= 2'd0;
			w_wait       <= 2'd0;
			ar_wait      <= 2'd0;
			aw_got       <= 1'b0;
			w_got        <= 1'b0;
			axi_bvalid_o <= 1'b0;
			axi_rvalid_o <= 1'b0;
			axi_b_o      <= '0;
			axi_r_o      <= '0;
		end else begin
			if (axi_awvalid_i && (aw_wait != 2'd0)) aw_wait <= aw_wait - 2'd1;
			if (axi_wvalid_i && (w_wait != 2'd0)) w_wait <= w_wait - 2'd1;
			if (axi_arvalid_i && (ar_wait != 2'd0)) ar_wait <= ar_wait - 2'd1;
			if (axi_bvalid_o && axi_bready_i) axi_bvalid_o <= 1'b0;
			if (axi_rvalid_o && axi_rready_i) axi_rvalid_o <= 1'b0;
			if (axi_awready_o) begin
				wr_addr <= axi_aw_i.addr;
				aw_got  <= 1'b1;
				draw_delay(d);
				aw_wait <= d;
			end
			if (axi_wready_o) begin
				wr_data <= axi_w_i.data;
				wr_strb <= axi_w_i.strb;
				w_got   <= 1'b1;
				draw_delay(d);
				w_wait  <= d;
			end
			// both halves of the write are in
			if (aw_got && w_got) begin
				if (wr_addr < ERR_BASE) begin
					for (int i = 0; i < 4; i++) begin
						if (wr_strb[i]) mem[wr_addr[IDX_BITS+1:2]][8*i +: 8] = wr_data[8*i +: 8];
					end
				end
				axi_b_o      <= '{resp: (wr_addr < ERR_BASE) ? AXI_RESP_OKAY : RESP_SLVERR, id: 4'd0};
				axi_bvalid_o <= 1'b1;
				aw_got       <= 1'b0;
				w_got        <= 1'b0;
			end
			if (axi_arready_o) begin
				if (axi_ar_i.addr < ERR_BASE) begin
					axi_r_o <= '{data: mem[axi_ar_i.addr[IDX_BITS+1:2]], resp: AXI_RESP_OKAY,
						id: 4'd0, last: 1'b1};
				end else begin
					axi_r_o <= '{data: '0, resp: RESP_SLVERR, id: 4'd0, last: 1'b1};
				end
				axi_rvalid_o <= 1'b1;
				draw_delay(d);
				ar_wait <= d;
			end
		end
	end

endmodule

// File: dv/tb_core_bus.sv
`timescale 1ns/1ps

module tb_core_bus
	import fabric_pkg::*;
();

	localparam addr_t TIMER_BASE      = 32'h0200_0000;
	localparam int    TIMER_SPAN      = 16;
	localparam int    MAX_CASES       = 32;
	localparam int    CASE_WORDS      = 7;
	localparam int    RESET_CYCLES    = 4;
	localparam int    CYCLES_PER_CASE = 64;

	logic       clock = 1'b0;
	logic       rst_n_i;
	fetch_req_t fetch_req;
	bus_rsp_t   fetch_rsp;
	bus_req_t   data_req;
	bus_rsp_t   data_rsp;

	axi_aw_t axi_aw;
	logic    axi_awvalid;
	logic    axi_awready;
	axi_w_t  axi_w;
	logic    axi_wvalid;
	logic    axi_wready;
	axi_b_t  axi_b;
	logic    axi_bvalid;
	logic    axi_bready;
	axi_ar_t axi_ar;
	logic    axi_arvalid;
	logic    axi_arready;
	axi_r_t  axi_r;
	logic    axi_rvalid;
	logic    axi_rready;

	logic [31:0] cases_mem [MAX_CASES*CASE_WORDS];
	int          num_cases;
	int          cycle_cnt = 0;
	int          cycle_limit = RESET_CYCLES + CYCLES_PER_CASE * MAX_CASES;
	int          errors = 0;
	int          axi_leaks = 0;
	int          passed_cases = 0;
	int          failed_cases = 0;
	logic        timer_case = 1'b0;
	data_t       last_tick = '0;

	always #4 clock = ~clock;

	core_bus_top #(
		.CLINT_BASE      (TIMER_BASE),
		.CLINT_SPAN_BITS (TIMER_SPAN)
	) u_dut (
		.clock(clock), .rst_n_i(rst_n_i),
		.fetch_req_i(fetch_req), .fetch_rsp_o(fetch_rsp),
		.data_req_i(data_req), .data_rsp_o(data_rsp),
		.axi_aw_o(axi_aw), .axi_awvalid_o(axi_awvalid), .axi_awready_i(axi_awready),
		.axi_w_o(axi_w), .axi_wvalid_o(axi_wvalid), .axi_wready_i(axi_wready),
		.axi_b_i(axi_b), .axi_bvalid_i(axi_bvalid), .axi_bready_o(axi_bready),
		.axi_ar_o(axi_ar), .axi_arvalid_o(axi_arvalid), .axi_arready_i(axi_arready),
		.axi_r_i(axi_r), .axi_rvalid_i(axi_rvalid), .axi_rready_o(axi_rready)
	);

	axi_mem_model u_mem (
		.clock(clock), .rst_n_i(rst_n_i),
		.axi_aw_i(axi_aw), .axi_awvalid_i(axi_awvalid), .axi_awready_o(axi_awready),
		.axi_w_i(axi_w), .axi_wvalid_i(axi_wvalid), .axi_wready_o(axi_wready),
		.axi_b_o(axi_b), .axi_bvalid_o(axi_bvalid), .axi_bready_i(axi_bready),
		.axi_ar_i(axi_ar), .axi_arvalid_i(axi_arvalid), .axi_arready_o(axi_arready),
		.axi_r_o(axi_r), .axi_rvalid_o(axi_rvalid), .axi_rready_i(axi_rready)
	);

	// ------------------------------------------------------------
	// run limit and timer isolation monitor
	// ------------------------------------------------------------
	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: the bus did not answer within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	// timer accesses must stay off the axi port
	always @(posedge clock) begin
		if (timer_case && (axi_arvalid || axi_awvalid)) begin
			$display("an AXI address channel went valid during a timer access");
			axi_leaks <= axi_leaks + 1;
		end
	end

	// every external transfer is one 4-byte incr beat with id 0
	always @(posedge clock) begin
		if (axi_arvalid && axi_arready) begin
			check_value("axi_ar.len", 32'(axi_ar.len), 32'h0);
			check_value("axi_ar.size", 32'(axi_ar.size), 32'h2);
			check_value("axi_ar.burst", 32'(axi_ar.burst), 32'h1);
			check_value("axi_ar.id", 32'(axi_ar.id), 32'h0);
		end
		if (axi_awvalid && axi_awready) begin
			check_value("axi_aw.len", 32'(axi_aw.len), 32'h0);
			check_value("axi_aw.size", 32'(axi_aw.size), 32'h2);
			check_value("axi_aw.burst", 32'(axi_aw.burst), 32'h1);
			check_value("axi_aw.id", 32'(axi_aw.id), 32'h0);
		end
		if (axi_wvalid && axi_wready) begin
			check_value("axi_w.last", 32'(axi_w.last), 32'h1);
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_rsp(input string who, input bus_rsp_t got, input logic [31:0] op,
			input data_t exp_rdata, input logic [31:0] exp_err);
		if (op == 32'd2) begin
			// mtime low word keeps counting between reads
			if (got.rdata <= last_tick) begin
				$display("%s: mtime did not advance, read 0x%08h after 0x%08h",
					who, got.rdata, last_tick);
				errors++;
			end
			last_tick = got.rdata;
		end else begin
			check_value({who, ".rdata"}, got.rdata, exp_rdata);
		end
		check_value({who, ".err"}, 32'(got.err), exp_err);
	endtask

	task automatic run_case(input int idx);
		logic [31:0] port;
		logic [31:0] op;
		addr_t       addr;
		data_t       wdata;
		logic [31:0] wstrb;
		data_t       exp_rdata;
		logic [31:0] exp_err;
		bus_rsp_t    d_got;
		bus_rsp_t    f_got;
		logic        d_done;
		logic        f_done;
		int          d_cyc;
		int          f_cyc;
		int          bad_before;
		port       = cases_mem[idx*CASE_WORDS];
		op         = cases_mem[idx*CASE_WORDS + 1];
		addr       = cases_mem[idx*CASE_WORDS + 2];
		wdata      = cases_mem[idx*CASE_WORDS + 3];
		wstrb      = cases_mem[idx*CASE_WORDS + 4];
		exp_rdata  = cases_mem[idx*CASE_WORDS + 5];
		exp_err    = cases_mem[idx*CASE_WORDS + 6];
		bad_before = errors + axi_leaks;
		d_got      = '0;
		f_got      = '0;
		d_cyc      = 0;
		f_cyc      = 0;
		d_done     = (port == 32'd0);
		f_done     = (port == 32'd1);

		@(negedge clock);
		timer_case = (addr[31:TIMER_SPAN] == TIMER_BASE[31:TIMER_SPAN]);
		if (!d_done) begin
			data_req = '{valid: 1'b1, write: (op == 32'd1), addr: addr, wdata: wdata,
				wstrb: wstrb[3:0]};
		end
		if (!f_done) begin
			fetch_req = '{valid: 1'b1, addr: addr};
		end

		// sample mid cycle, release each port in the cycle after its response
		while (!(d_done && f_done)) begin
			@(negedge clock);
			if (d_done) data_req.valid = 1'b0;
			if (f_done) fetch_req.valid = 1'b0;
			if (data_rsp.valid) begin
				if (d_done) begin
					$display("case %0d: data response without a pending data request", idx);
					errors++;
				end
				d_got  = data_rsp;
				d_done = 1'b1;
				d_cyc  = cycle_cnt;
			end
			if (fetch_rsp.valid) begin
				if (f_done) begin
					$display("case %0d: fetch response without a pending fetch request", idx);
					errors++;
				end
				f_got  = fetch_rsp;
				f_done = 1'b1;
				f_cyc  = cycle_cnt;
			end
		end
		@(negedge clock);
		data_req.valid  = 1'b0;
		fetch_req.valid = 1'b0;
		timer_case      = 1'b0;

		if (port != 32'd0) check_rsp("data_rsp", d_got, op, exp_rdata, exp_err);
		if (port != 32'd1) check_rsp("fetch_rsp", f_got, op, exp_rdata, exp_err);
		if ((port == 32'd2) && (d_cyc >= f_cyc)) begin
			$display("case %0d: fetch response did not come after the data response", idx);
			errors++;
		end

		if (errors + axi_leaks == bad_before) begin
			passed_cases++;
			$display("case %0d ok: port %0d op %0d addr 0x%08h", idx, port, op, addr);
		end else begin
			failed_cases++;
			$display("case %0d failed: port %0d op %0d addr 0x%08h", idx, port, op, addr);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		rst_n_i   = 1'b0;
		fetch_req = '0;
		data_req  = '0;
		// all ones marks the end of the case list
		for (int i = 0; i < MAX_CASES*CASE_WORDS; i++) begin
			cases_mem[i] = '1;
		end
		$readmemh("dv/bus_cases.txt", cases_mem);
		num_cases = 0;
		while ((num_cases < MAX_CASES) && (cases_mem[num_cases*CASE_WORDS] != '1)) begin
			num_cases++;
		end
		cycle_limit = RESET_CYCLES + CYCLES_PER_CASE * num_cases;

		repeat (RESET_CYCLES) @(negedge clock);
		rst_n_i = 1'b1;

		for (int i = 0; i < num_cases; i++) begin
			run_case(i);
		end

		$display("cases %0d, passed %0d, failed %0d, errors %0d", num_cases, passed_cases,
			failed_cases, errors + axi_leaks);
		if ((errors == 0) && (axi_leaks == 0) && (num_cases > 0)) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: dv/bus_cases.txt
// port op addr wdata wstrb exp_rdata exp_err, all hex
// port 0 fetch 1 data 2 both, op 0 read 1 write 2 mtime read above the last one
1 1 80000100 11223344 f 00000000 0
1 0 80000100 00000000 f 11223344 0
1 1 80000100 aabbccdd 5 00000000 0
1 0 80000100 00000000 f 11bb33dd 0
1 0 80000204 00000000 f c0de0204 0
1 1 80000204 55667788 c 00000000 0
1 0 80000204 00000000 f 55660204 0
0 0 80000100 00000000 f 11bb33dd 0
0 0 80000010 00000000 f c0de0010 0
2 0 80000204 00000000 f 55660204 0
2 0 80000100 00000000 f 11bb33dd 0
1 1 0200bffc 12345678 f 00000000 0
1 0 0200bffc 00000000 f 12345678 0
0 0 0200bffc 00000000 f 12345678 0
1 2 0200bff8 00000000 f 00000000 0
1 2 0200bff8 00000000 f 00000000 0
0 2 0200bff8 00000000 f 00000000 0
1 0 02000000 00000000 f 00000000 0
1 1 f0000010 0badf00d f 00000000 1
1 0 f0000010 00000000 f 00000000 1
0 0 f0000100 00000000 f 00000000 1
1 0 80000100 00000000 f 11bb33dd 0

// File: project.f
hdl/fabric_pkg.sv
hdl/bus_arbiter.sv
hdl/addr_xbar.sv
hdl/clint_timer.sv
hdl/axi4_master_bridge.sv
hdl/core_bus_top.sv
dv/axi_mem_model.sv
dv/tb_core_bus.sv

// File: Makefile
# verilator build and run of the bus fabric testbench
TOP := tb_core_bus

all: run

obj_dir/V$(TOP): project.f hdl/*.sv dv/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TB PASSED" sim.log

lint:
	verilator --lint-only --top-module core_bus_top hdl/fabric_pkg.sv hdl/bus_arbiter.sv \
		hdl/addr_xbar.sv hdl/clint_timer.sv hdl/axi4_master_bridge.sv hdl/core_bus_top.sv
	verilator --lint-only --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
